/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_vbus_buffer
FILELIST = vbus_buffer_top.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "RESULT: PASS" $(LOG); then echo "simulation ended early"; exit 1; fi

lint:
	$(TOOL) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* common/csr_pkg.sv */
// ##########################################################
// vbus stream buffer: APB register map and field positions
// ##########################################################
package csr_pkg;

  localparam int APB_ADDR_WIDTH = 8;
  localparam int APB_DATA_WIDTH = 32;

  localparam logic [APB_ADDR_WIDTH-1:0] CTRL_ADDR   = 8'h00;
  localparam logic [APB_ADDR_WIDTH-1:0] STATUS_ADDR = 8'h04;
  localparam logic [APB_ADDR_WIDTH-1:0] DROP_ADDR   = 8'h08;
  localparam logic [APB_ADDR_WIDTH-1:0] PKT_ADDR    = 8'h0C;

  // CTRL fields
  localparam int   CTRL_ENABLE_BIT   = 0;
  localparam int   CTRL_CLEAR_BIT    = 1;
  localparam logic CTRL_ENABLE_RESET = 1'b1;

  // STATUS fields
  localparam int STATUS_EMPTY_BIT  = 0;
  localparam int STATUS_AFULL_BIT  = 1;
  localparam int STATUS_FULL_BIT   = 2;
  localparam int STATUS_COUNT_LSB  = 8;

endpackage

/* common/vbus_if.sv */
// ##########################################################
// vbus stream interface, valid plus payload, no ready
// ##########################################################
`timescale 1ns/1ps

interface vbus_if;
  import vbus_pkg::*;

  logic                  valid;
  logic [DATA_WIDTH-1:0] data;
  logic [TAG_WIDTH-1:0]  tag;
  logic                  last;

  // the producing side
  modport master (
    output valid,
    output data,
    output tag,
    output last
  );

  modport slave (
    input valid,
    input data,
    input tag,
    input last
  );

endinterface

/* common/vbus_pkg.sv */
// ##########################################################
// vbus stream buffer: bus widths, beat layout, buffer sizing
// ##########################################################
package vbus_pkg;

  localparam int DATA_WIDTH     = 32;
  localparam int TAG_WIDTH      = 4;

  // buffer entries and the almost-full level
  localparam int FIFO_DEPTH     = 8;
  localparam int FIFO_THRESHOLD = 6;

  // must hold the value FIFO_DEPTH itself
  localparam int COUNT_WIDTH    = $clog2(FIFO_DEPTH + 1);

  // one stored beat per FIFO word
  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic [TAG_WIDTH-1:0]  tag;
    logic                  last;
  } vbus_beat_t;

endpackage

/* fifo/generic_fifo.sv */
// ##########################################################
// synchronous FIFO, registered flags and count, FWFT head
// ##########################################################
`timescale 1ns/1ps

module generic_fifo #(
  parameter int  DEPTH     = 8,
  parameter int  THRESHOLD = DEPTH,
  parameter type TYPE      = logic
) (
  input  logic                         i_clk,
  input  logic                         i_rst_n,
  input  logic                         i_clear,
  input  logic                         i_push,
  input  TYPE                          i_data,
  input  logic                         i_pop,
  output TYPE                          o_data,
  output logic                         o_empty,
  output logic                         o_almost_full,
  output logic                         o_full,
  output logic [$clog2(DEPTH+1)-1:0]   o_word_count
);
  localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_WIDTH = $clog2(DEPTH + 1);

  TYPE                  mem [DEPTH];
  logic [PTR_WIDTH-1:0] wr_ptr;
  logic [PTR_WIDTH-1:0] rd_ptr;
  logic [CNT_WIDTH-1:0] count;
  logic [CNT_WIDTH-1:0] count_next;
  logic                 push_en;
  logic                 pop_en;

  assign push_en = i_push && !o_full;
  assign pop_en  = i_pop && !o_empty;

  always_comb begin
    case ({push_en, pop_en})
      2'b10:   count_next = count + 1'b1;
      2'b01:   count_next = count - 1'b1;
      // push and pop together leave the level alone
      default: count_next = count;
    endcase
  end

  // storage, written only on an accepted push
  always_ff @(posedge i_clk) begin
    if (push_en) begin
      mem[wr_ptr] <= i_data;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n || i_clear) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      o_empty       <= 1'b1;
      o_almost_full <= 1'b0;
      o_full        <= 1'b0;
    end else begin
      if (push_en) begin
        wr_ptr <= (wr_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_en) begin
        rd_ptr <= (rd_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count         <= count_next;
      // flags follow the next level so they are exact every cycle
      o_empty       <= (count_next == '0);
      o_almost_full <= (count_next >= CNT_WIDTH'(THRESHOLD));
      o_full        <= (count_next == CNT_WIDTH'(DEPTH));
    end
  end

  // first word falls through
  assign o_data       = mem[rd_ptr];
  assign o_word_count = count;

  a_no_push_when_full: assert property (
    @(posedge i_clk) disable iff (!i_rst_n) i_push |-> !o_full
  ) else $error("push into a full FIFO");

  a_no_pop_when_empty: assert property (
    @(posedge i_clk) disable iff (!i_rst_n) i_pop |-> !o_empty
  ) else $error("pop from an empty FIFO");

endmodule

/* fifo/vbus_fifo.sv */
// ##########################################################
// vbus FIFO, stores interface beats in the generic FIFO
// ##########################################################
`timescale 1ns/1ps

module vbus_fifo (
  input  logic                             i_clk,
  input  logic                             i_rst_n,
  input  logic                             i_clear,
  input  logic                             i_push,
  input  logic                             i_pop,
  vbus_if.slave                            slave_if,
  vbus_if.master                           master_if,
  output logic                             o_empty,
  output logic                             o_almost_full,
  output logic                             o_full,
  output logic [vbus_pkg::COUNT_WIDTH-1:0] o_word_count
);
  import vbus_pkg::*;

  vbus_beat_t in_beat;
  vbus_beat_t head_beat;

  assign in_beat.data = slave_if.data;
  assign in_beat.tag  = slave_if.tag;
  assign in_beat.last = slave_if.last;

  generic_fifo #(
    .DEPTH     (FIFO_DEPTH    ),
    .THRESHOLD (FIFO_THRESHOLD),
    .TYPE      (vbus_beat_t   )
  ) u_fifo (
    .i_clk         (i_clk        ),
    .i_rst_n       (i_rst_n      ),
    .i_clear       (i_clear      ),
    .i_push        (i_push       ),
    .i_data        (in_beat      ),
    .i_pop         (i_pop        ),
    .o_data        (head_beat    ),
    .o_empty       (o_empty      ),
    .o_almost_full (o_almost_full),
    .o_full        (o_full       ),
    .o_word_count  (o_word_count )
  );

  // head is only a beat while something is stored
  assign master_if.valid = !o_empty;
  assign master_if.data  = head_beat.data;
  assign master_if.tag   = head_beat.tag;
  assign master_if.last  = head_beat.last;

  a_push_has_beat: assert property (
    @(posedge i_clk) disable iff (!i_rst_n) i_push |-> slave_if.valid
  ) else $error("push without a beat on the ingress bus");

endmodule

/* src/vbus_buffer_top.sv */
// ##########################################################
// vbus stream buffer top: ingress, FIFO, egress and APB CSR
// ##########################################################
`timescale 1ns/1ps

module vbus_buffer_top (
  input  logic                               i_clk,
  input  logic                               i_rst_n,
  input  logic                               i_in_valid,
  input  logic [vbus_pkg::DATA_WIDTH-1:0]    i_in_data,
  input  logic [vbus_pkg::TAG_WIDTH-1:0]     i_in_tag,
  input  logic                               i_in_last,
  input  logic                               i_out_ready,
  output logic                               o_out_valid,
  output logic [vbus_pkg::DATA_WIDTH-1:0]    o_out_data,
  output logic [vbus_pkg::TAG_WIDTH-1:0]     o_out_tag,
  output logic                               o_out_last,
  input  logic                               i_psel,
  input  logic                               i_penable,
  input  logic                               i_pwrite,
  input  logic [csr_pkg::APB_ADDR_WIDTH-1:0] i_paddr,
  input  logic [csr_pkg::APB_DATA_WIDTH-1:0] i_pwdata,
  output logic [csr_pkg::APB_DATA_WIDTH-1:0] o_prdata,
  output logic                               o_pready,
  output logic                               o_pslverr
);
  import vbus_pkg::*;

  logic                   enable;
  logic                   clear;
  logic                   push;
  logic                   pop;
  logic                   drop;
  logic                   packet_done;
  logic                   empty;
  logic                   almost_full;
  logic                   full;
  logic [COUNT_WIDTH-1:0] word_count;

  // ingress register to FIFO, FIFO head to egress
  vbus_if ing_if ();
  vbus_if egr_if ();

  vbus_ingress u_ingress (
    .i_clk      (i_clk     ),
    .i_rst_n    (i_rst_n   ),
    .i_enable   (enable    ),
    .i_clear    (clear     ),
    .i_in_valid (i_in_valid),
    .i_in_data  (i_in_data ),
    .i_in_tag   (i_in_tag  ),
    .i_in_last  (i_in_last ),
    .i_full     (full      ),
    .o_push     (push      ),
    .o_drop     (drop      ),
    .out_if     (ing_if    )
  );

  vbus_fifo u_fifo (
    .i_clk         (i_clk      ),
    .i_rst_n       (i_rst_n    ),
    .i_clear       (clear      ),
    .i_push        (push       ),
    .i_pop         (pop        ),
    .slave_if      (ing_if     ),
    .master_if     (egr_if     ),
    .o_empty       (empty      ),
    .o_almost_full (almost_full),
    .o_full        (full       ),
    .o_word_count  (word_count )
  );

  vbus_egress u_egress (
    .i_clk         (i_clk      ),
    .i_rst_n       (i_rst_n    ),
    .i_clear       (clear      ),
    .in_if         (egr_if     ),
    .o_pop         (pop        ),
    .i_out_ready   (i_out_ready),
    .o_out_valid   (o_out_valid),
    .o_out_data    (o_out_data ),
    .o_out_tag     (o_out_tag  ),
    .o_out_last    (o_out_last ),
    .o_packet_done (packet_done)
  );

  vbus_csr u_csr (
    .i_clk         (i_clk      ),
    .i_rst_n       (i_rst_n    ),
    .i_psel        (i_psel     ),
    .i_penable     (i_penable  ),
    .i_pwrite      (i_pwrite   ),
    .i_paddr       (i_paddr    ),
    .i_pwdata      (i_pwdata   ),
    .o_prdata      (o_prdata   ),
    .o_pready      (o_pready   ),
    .o_pslverr     (o_pslverr  ),
    .i_empty       (empty      ),
    .i_almost_full (almost_full),
    .i_full        (full       ),
    .i_word_count  (word_count ),
    .i_drop        (drop       ),
    .i_packet_done (packet_done),
    .o_enable      (enable     ),
    .o_clear       (clear      )
  );

endmodule

/* src/vbus_csr.sv */
// ##########################################################
// APB register block for control, FIFO status and counters
// ##########################################################
`timescale 1ns/1ps

module vbus_csr (
  input  logic                               i_clk,
  input  logic                               i_rst_n,
  input  logic                               i_psel,
  input  logic                               i_penable,
  input  logic                               i_pwrite,
  input  logic [csr_pkg::APB_ADDR_WIDTH-1:0] i_paddr,
  input  logic [csr_pkg::APB_DATA_WIDTH-1:0] i_pwdata,
  output logic [csr_pkg::APB_DATA_WIDTH-1:0] o_prdata,
  output logic                               o_pready,
  output logic                               o_pslverr,
  input  logic                               i_empty,
  input  logic                               i_almost_full,
  input  logic                               i_full,
  input  logic [vbus_pkg::COUNT_WIDTH-1:0]   i_word_count,
  input  logic                               i_drop,
  input  logic                               i_packet_done,
  output logic                               o_enable,
  output logic                               o_clear
);
  import csr_pkg::*;
  import vbus_pkg::*;

  logic                      access;
  logic                      ctrl_write;
  logic                      mapped;
  logic                      enable_q;
  logic [APB_DATA_WIDTH-1:0] drop_cnt;
  logic [APB_DATA_WIDTH-1:0] pkt_cnt;

  // the access phase is never stretched
  assign access     = i_psel && i_penable;
  assign ctrl_write = access && i_pwrite && (i_paddr == CTRL_ADDR);
  assign o_pready   = 1'b1;

  // write-one clear acts in the access cycle itself
  assign o_clear  = ctrl_write && i_pwdata[CTRL_CLEAR_BIT];
  assign o_enable = enable_q;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      enable_q <= CTRL_ENABLE_RESET;
    end else if (ctrl_write) begin
      enable_q <= i_pwdata[CTRL_ENABLE_BIT];
    end
  end

  // both counters stop at all ones
  always_ff @(posedge i_clk) begin
    if (!i_rst_n || o_clear) begin
      drop_cnt <= '0;
      pkt_cnt  <= '0;
    end else begin
      if (i_drop && drop_cnt != '1) begin
        drop_cnt <= drop_cnt + 1'b1;
      end
      if (i_packet_done && pkt_cnt != '1) begin
        pkt_cnt <= pkt_cnt + 1'b1;
      end
    end
  end

  always_comb begin
    mapped   = 1'b1;
    o_prdata = '0;
    case (i_paddr)
      CTRL_ADDR: o_prdata[CTRL_ENABLE_BIT] = enable_q;
      STATUS_ADDR: begin
        o_prdata[STATUS_EMPTY_BIT]                     = i_empty;
        o_prdata[STATUS_AFULL_BIT]                     = i_almost_full;
        o_prdata[STATUS_FULL_BIT]                      = i_full;
        o_prdata[STATUS_COUNT_LSB +: COUNT_WIDTH]      = i_word_count;
      end
      DROP_ADDR: o_prdata = drop_cnt;
      PKT_ADDR:  o_prdata = pkt_cnt;
      default:   mapped = 1'b0;
    endcase
  end

  assign o_pslverr = access && !mapped;

  // the flags returned in STATUS agree with the word count
  a_status_consistent: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    (i_empty == (i_word_count == '0)) &&
    (i_full == (i_word_count == COUNT_WIDTH'(FIFO_DEPTH)))
  ) else $error("STATUS flags disagree with the word count");

endmodule

/* src/vbus_egress.sv */
// ##########################################################
// vbus egress register, pops the FIFO under output ready
// ##########################################################
`timescale 1ns/1ps

module vbus_egress (
  input  logic                            i_clk,
  input  logic                            i_rst_n,
  input  logic                            i_clear,
  vbus_if.slave                           in_if,
  output logic                            o_pop,
  input  logic                            i_out_ready,
  output logic                            o_out_valid,
  output logic [vbus_pkg::DATA_WIDTH-1:0] o_out_data,
  output logic [vbus_pkg::TAG_WIDTH-1:0]  o_out_tag,
  output logic                            o_out_last,
  output logic                            o_packet_done
);
  import vbus_pkg::*;

  logic       valid_q;
  logic       room;
  vbus_beat_t beat_q;

  // free, or the held beat leaves this cycle
  assign room  = !valid_q || i_out_ready;
  assign o_pop = in_if.valid && room;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n || i_clear) begin
      valid_q <= 1'b0;
    end else if (room) begin
      valid_q <= in_if.valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_pop) begin
      beat_q.data <= in_if.data;
      beat_q.tag  <= in_if.tag;
      beat_q.last <= in_if.last;
    end
  end

  assign o_out_valid   = valid_q;
  assign o_out_data    = beat_q.data;
  assign o_out_tag     = beat_q.tag;
  assign o_out_last    = beat_q.last;
  assign o_packet_done = valid_q && i_out_ready && beat_q.last;

  // a stalled beat stays on the bus unchanged
  a_hold_under_stall: assert property (
    @(posedge i_clk) disable iff (!i_rst_n || i_clear)
    (o_out_valid && !i_out_ready) |=> (o_out_valid && $stable(beat_q))
  ) else $error("output beat changed while stalled");

endmodule

/* src/vbus_ingress.sv */
// ##########################################################
// vbus ingress stage that registers beats and drops on overflow
// ##########################################################
`timescale 1ns/1ps

module vbus_ingress (
  input  logic                            i_clk,
  input  logic                            i_rst_n,
  input  logic                            i_enable,
  input  logic                            i_clear,
  input  logic                            i_in_valid,
  input  logic [vbus_pkg::DATA_WIDTH-1:0] i_in_data,
  input  logic [vbus_pkg::TAG_WIDTH-1:0]  i_in_tag,
  input  logic                            i_in_last,
  input  logic                            i_full,
  output logic                            o_push,
  output logic                            o_drop,
  vbus_if.master                          out_if
);
  import vbus_pkg::*;

  logic                  accept;
  logic                  valid_q;
  logic [DATA_WIDTH-1:0] data_q;
  logic [TAG_WIDTH-1:0]  tag_q;
  logic                  last_q;

  // disabled input is ignored and not counted as a drop
  assign accept = i_in_valid && i_enable;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n || i_clear) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= accept;
    end
  end

  always_ff @(posedge i_clk) begin
    if (accept) begin
      data_q <= i_in_data;
      tag_q  <= i_in_tag;
      last_q <= i_in_last;
    end
  end

  assign out_if.valid = valid_q;
  assign out_if.data  = data_q;
  assign out_if.tag   = tag_q;
  assign out_if.last  = last_q;

  assign o_push = valid_q && !i_full;
  assign o_drop = valid_q && i_full;

  // an accepted beat is pushed or dropped one cycle later, never both
  a_push_xor_drop: assert property (
    @(posedge i_clk) disable iff (!i_rst_n || i_clear)
    (i_in_valid && i_enable) |=> (o_push ^ o_drop)
  ) else $error("accepted beat not pushed or dropped exactly once");

endmodule

/* vbus_buffer_top.f */
common/vbus_pkg.sv
common/csr_pkg.sv
common/vbus_if.sv
fifo/generic_fifo.sv
fifo/vbus_fifo.sv
src/vbus_ingress.sv
src/vbus_egress.sv
src/vbus_csr.sv
src/vbus_buffer_top.sv
verif/tb_vbus_buffer.sv

/* verif/tb_vbus_buffer.sv */
// ##########################################################
// vbus stream buffer testbench, table stimulus, scoreboard
// ##########################################################
`timescale 1ns/1ps

module tb_vbus_buffer;
  import vbus_pkg::*;
  import csr_pkg::*;

  localparam int CLK_PERIOD      = 8;
  localparam int NUM_ROWS        = 12;
  localparam int OVERFLOW_BEATS  = FIFO_DEPTH + 4;
  localparam int WATCHDOG_CYCLES = NUM_ROWS * 20 + 2000;

  // the output must repeat data, tag and last of each row
  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic [TAG_WIDTH-1:0]  tag;
    logic                  last;
    logic                  stall;
  } row_t;

  row_t rows [NUM_ROWS] = '{
    '{32'h1000_0001, 4'h1, 1'b0, 1'b1},
    '{32'h1000_0002, 4'h1, 1'b0, 1'b1},
    '{32'h1000_0003, 4'h1, 1'b1, 1'b0},
    '{32'h2000_0004, 4'h2, 1'b0, 1'b1},
    '{32'h2000_0005, 4'h2, 1'b1, 1'b1},
    '{32'h3000_0006, 4'h3, 1'b0, 1'b0},
    '{32'h3000_0007, 4'h3, 1'b0, 1'b1},
    '{32'h3000_0008, 4'h3, 1'b0, 1'b1},
    '{32'h3000_0009, 4'h3, 1'b1, 1'b1},
    '{32'hDEAD_BEEF, 4'hA, 1'b1, 1'b0},
    '{32'h0000_0000, 4'hF, 1'b0, 1'b1},
    '{32'hFFFF_FFFF, 4'h0, 1'b1, 1'b1}
  };

  logic                      i_clk = 1'b0;
  logic                      i_rst_n;
  logic                      i_in_valid;
  logic [DATA_WIDTH-1:0]     i_in_data;
  logic [TAG_WIDTH-1:0]      i_in_tag;
  logic                      i_in_last;
  logic                      i_out_ready = 1'b1;
  logic                      o_out_valid;
  logic [DATA_WIDTH-1:0]     o_out_data;
  logic [TAG_WIDTH-1:0]      o_out_tag;
  logic                      o_out_last;
  logic                      i_psel;
  logic                      i_penable;
  logic                      i_pwrite;
  logic [APB_ADDR_WIDTH-1:0] i_paddr;
  logic [APB_DATA_WIDTH-1:0] i_pwdata;
  logic [APB_DATA_WIDTH-1:0] o_prdata;
  logic                      o_pready;
  logic                      o_pslverr;

  // scoreboard queue and ready shaping
  vbus_beat_t exp_q [$];
  vbus_beat_t mon_exp;
  vbus_beat_t held;
  logic       ready_pattern [256];
  logic [7:0] pat_idx      = '0;
  logic       ready_random = 1'b0;
  logic       ready_level  = 1'b1;
  logic       hold_check   = 1'b0;
  logic       stalled      = 1'b0;
  int         error_count  = 0;

  vbus_buffer_top u_dut (
    .i_clk       (i_clk      ),
    .i_rst_n     (i_rst_n    ),
    .i_in_valid  (i_in_valid ),
    .i_in_data   (i_in_data  ),
    .i_in_tag    (i_in_tag   ),
    .i_in_last   (i_in_last  ),
    .i_out_ready (i_out_ready),
    .o_out_valid (o_out_valid),
    .o_out_data  (o_out_data ),
    .o_out_tag   (o_out_tag  ),
    .o_out_last  (o_out_last ),
    .i_psel      (i_psel     ),
    .i_penable   (i_penable  ),
    .i_pwrite    (i_pwrite   ),
    .i_paddr     (i_paddr    ),
    .i_pwdata    (i_pwdata   ),
    .o_prdata    (o_prdata   ),
    .o_pready    (o_pready   ),
    .o_pslverr   (o_pslverr  )
  );

  always #(CLK_PERIOD / 2) i_clk = ~i_clk;

  // ready is either a fixed level or a precomputed random pattern
  always @(posedge i_clk) begin
    if (ready_random) begin
      i_out_ready <= ready_pattern[pat_idx];
      pat_idx     <= pat_idx + 8'd1;
    end else begin
      i_out_ready <= ready_level;
    end
  end

  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string what);
    if (actual !== expected) begin
      error_count++;
      $display("Error: time %0t: %s, expected 0x%08h, got 0x%08h",
               $time, what, expected, actual);
      $display("RESULT: FAIL");
      $fatal(1, "stopping on first mismatch");
    end
  endtask

  task automatic apb_write(input logic [APB_ADDR_WIDTH-1:0] addr,
                           input logic [APB_DATA_WIDTH-1:0] data);
    @(posedge i_clk);
    i_psel    <= 1'b1;
    i_penable <= 1'b0;
    i_pwrite  <= 1'b1;
    i_paddr   <= addr;
    i_pwdata  <= data;
    @(posedge i_clk);
    i_penable <= 1'b1;
    @(posedge i_clk);
    i_psel    <= 1'b0;
    i_penable <= 1'b0;
  endtask

  // samples the access phase at the edge that closes it
  task automatic apb_read(input logic [APB_ADDR_WIDTH-1:0] addr,
                          output logic [APB_DATA_WIDTH-1:0] data, output logic err);
    @(posedge i_clk);
    i_psel    <= 1'b1;
    i_penable <= 1'b0;
    i_pwrite  <= 1'b0;
    i_paddr   <= addr;
    @(posedge i_clk);
    i_penable <= 1'b1;
    @(posedge i_clk);
    data = o_prdata;
    err  = o_pslverr;
    check(32'(o_pready), 32'd1, "pready in access phase");
    i_psel    <= 1'b0;
    i_penable <= 1'b0;
  endtask

  task automatic apb_expect(input logic [APB_ADDR_WIDTH-1:0] addr,
                            input logic [APB_DATA_WIDTH-1:0] expected, input string what);
    logic [APB_DATA_WIDTH-1:0] data;
    logic                      err;
    apb_read(addr, data, err);
    check(32'(err), 32'd0, {what, " pslverr"});
    check(data, expected, what);
  endtask

  task automatic drive_beat(input row_t r, input logic expect_out);
    vbus_beat_t b;
    i_in_valid <= 1'b1;
    i_in_data  <= r.data;
    i_in_tag   <= r.tag;
    i_in_last  <= r.last;
    if (expect_out) begin
      b.data = r.data;
      b.tag  = r.tag;
      b.last = r.last;
      exp_q.push_back(b);
    end
  endtask

  task automatic drive_idle();
    i_in_valid <= 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      @(posedge i_clk);
    end
    repeat (2) @(posedge i_clk);
  endtask

  function automatic logic [31:0] status_word(input logic empty, input logic afull,
                                              input logic full, input int count);
    logic [31:0] w;
    w                   = '0;
    w[STATUS_EMPTY_BIT] = empty;
    w[STATUS_AFULL_BIT] = afull;
    w[STATUS_FULL_BIT]  = full;
    w[11:8]             = 4'(count);
    return w;
  endfunction

  function automatic int count_last();
    int n;
    n = 0;
    foreach (rows[k]) begin
      if (rows[k].last) n++;
    end
    return n;
  endfunction

  // overflow beats, the last one kept by the buffer closes a packet
  function automatic row_t overflow_row(input int n);
    row_t r;
    r.data  = 32'hA5A5_0000 + 32'(n);
    r.tag   = 4'(n);
    r.last  = (n == FIFO_DEPTH);
    r.stall = 1'b1;
    return r;
  endfunction

  // scoreboard and stall hold check
  always @(posedge i_clk) begin
    if (i_rst_n) begin
      if (hold_check && stalled) begin
        check(32'(o_out_valid), 32'd1, "output valid dropped under stall");
        check(o_out_data, held.data, "output data changed under stall");
        check(32'(o_out_tag), 32'(held.tag), "output tag changed under stall");
        check(32'(o_out_last), 32'(held.last), "output last changed under stall");
      end
      if (o_out_valid && i_out_ready) begin
        check(32'(exp_q.size() != 0), 32'd1, "output beat with none expected");
        mon_exp = exp_q.pop_front();
        check(o_out_data, mon_exp.data, "output data");
        check(32'(o_out_tag), 32'(mon_exp.tag), "output tag");
        check(32'(o_out_last), 32'(mon_exp.last), "output last");
      end
      stalled   = o_out_valid && !i_out_ready;
      held.data = o_out_data;
      held.tag  = o_out_tag;
      held.last = o_out_last;
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge i_clk);
    $display("watchdog expired before the test sequence finished");
    $display("RESULT: FAIL");
    $fatal(1, "run stopped by watchdog");
  end

  initial begin : main_seq
    int i;
    int n_last;
    logic [31:0] rd_data;
    logic        rd_err;
    void'($urandom(55498));
    foreach (ready_pattern[k]) begin
      ready_pattern[k] = 1'($urandom % 2);
    end
    i_rst_n    = 1'b0;
    i_in_valid = 1'b0;
    i_in_data  = '0;
    i_in_tag   = '0;
    i_in_last  = 1'b0;
    i_psel     = 1'b0;
    i_penable  = 1'b0;
    i_pwrite   = 1'b0;
    i_paddr    = '0;
    i_pwdata   = '0;
    n_last     = count_last();
    repeat (4) @(posedge i_clk);
    i_rst_n    <= 1'b1;
    hold_check <= 1'b1;
    @(posedge i_clk);

    // register map after reset, unmapped address errors
    apb_read(8'h10, rd_data, rd_err);
    check(32'(rd_err), 32'd1, "pslverr on unmapped address");
    apb_expect(CTRL_ADDR, 32'h1, "CTRL after reset");
    apb_expect(STATUS_ADDR, status_word(1'b1, 1'b0, 1'b0, 0), "STATUS after reset");
    apb_expect(DROP_ADDR, 32'd0, "drop count after reset");
    apb_expect(PKT_ADDR, 32'd0, "packet count after reset");

    // pass-through with ready held high
    for (i = 0; i < NUM_ROWS; i++) begin
      @(posedge i_clk);
      drive_beat(rows[i], 1'b1);
    end
    @(posedge i_clk);
    drive_idle();
    wait_drain();
    apb_expect(PKT_ADDR, 32'(n_last), "packet count after pass-through");

    // random back-pressure, at most FIFO_DEPTH beats in flight
    i = 0;
    while (i < NUM_ROWS) begin
      @(posedge i_clk);
      ready_random <= rows[i].stall;
      if (exp_q.size() < FIFO_DEPTH) begin
        drive_beat(rows[i], 1'b1);
        i++;
      end else begin
        drive_idle();
      end
    end
    @(posedge i_clk);
    drive_idle();
    ready_random <= 1'b0;
    wait_drain();
    apb_expect(DROP_ADDR, 32'd0, "drop count after back-pressure");
    apb_expect(PKT_ADDR, 32'(2 * n_last), "packet count after back-pressure");

    // overflow, egress register plus FIFO keep FIFO_DEPTH + 1 beats
    @(posedge i_clk);
    ready_level <= 1'b0;
    @(posedge i_clk);
    for (i = 0; i < OVERFLOW_BEATS; i++) begin
      @(posedge i_clk);
      drive_beat(overflow_row(i), i <= FIFO_DEPTH);
    end
    @(posedge i_clk);
    drive_idle();
    repeat (4) @(posedge i_clk);
    apb_expect(STATUS_ADDR, status_word(1'b0, 1'b1, 1'b1, FIFO_DEPTH), "STATUS when full");
    apb_expect(DROP_ADDR, 32'(OVERFLOW_BEATS - FIFO_DEPTH - 1), "drop count after overflow");
    @(posedge i_clk);
    ready_level <= 1'b1;
    wait_drain();
    apb_expect(PKT_ADDR, 32'(2 * n_last + 1), "packet count after overflow");

    // ingress disabled, beats vanish without drops
    apb_write(CTRL_ADDR, 32'h0);
    for (i = 0; i < 4; i++) begin
      @(posedge i_clk);
      drive_beat(rows[i], 1'b0);
    end
    @(posedge i_clk);
    drive_idle();
    repeat (8) @(posedge i_clk);
    apb_expect(CTRL_ADDR, 32'h0, "CTRL with ingress disabled");
    apb_expect(STATUS_ADDR, status_word(1'b1, 1'b0, 1'b0, 0), "STATUS with ingress disabled");
    apb_expect(DROP_ADDR, 32'(OVERFLOW_BEATS - FIFO_DEPTH - 1), "drop count while disabled");

    // fill under stall, then clear drops the held beats
    apb_write(CTRL_ADDR, 32'h1);
    @(posedge i_clk);
    ready_level <= 1'b0;
    hold_check  <= 1'b0;
    @(posedge i_clk);
    for (i = 0; i < 5; i++) begin
      @(posedge i_clk);
      drive_beat(rows[i], 1'b0);
    end
    @(posedge i_clk);
    drive_idle();
    repeat (4) @(posedge i_clk);
    apb_expect(STATUS_ADDR, status_word(1'b0, 1'b0, 1'b0, 4), "STATUS before clear");
    apb_write(CTRL_ADDR, 32'h3);
    apb_expect(STATUS_ADDR, status_word(1'b1, 1'b0, 1'b0, 0), "STATUS after clear");
    apb_expect(DROP_ADDR, 32'd0, "drop count after clear");
    apb_expect(PKT_ADDR, 32'd0, "packet count after clear");
    apb_expect(CTRL_ADDR, 32'h1, "CTRL after clear");
    check(32'(o_out_valid), 32'd0, "output valid after clear");
    @(posedge i_clk);
    ready_level <= 1'b1;
    repeat (8) @(posedge i_clk);

    if (error_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
